//--- mips_isa_pkg.sv
package mips_isa_pkg;

    // Instruction field widths
    localparam int OP_W     = 6;
    localparam int FN_W     = 6;
    localparam int REG_W    = 5;
    localparam int IMM_W    = 16;
    localparam int TARGET_W = 26;

    // Opcodes
    localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
    localparam logic [OP_W-1:0] OP_J     = 6'h02;
    localparam logic [OP_W-1:0] OP_BEQ   = 6'h04;
    localparam logic [OP_W-1:0] OP_ADDI  = 6'h08;
    localparam logic [OP_W-1:0] OP_LW    = 6'h23;
    localparam logic [OP_W-1:0] OP_SW    = 6'h2b;

    // R-type funct codes
    localparam logic [FN_W-1:0] FN_SLL = 6'h00;
    localparam logic [FN_W-1:0] FN_ADD = 6'h20;
    localparam logic [FN_W-1:0] FN_SUB = 6'h22;
    localparam logic [FN_W-1:0] FN_AND = 6'h24;
    localparam logic [FN_W-1:0] FN_OR  = 6'h25;
    localparam logic [FN_W-1:0] FN_SLT = 6'h2a;

    // One fetched word, seen as R, I or J format
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]  op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [REG_W-1:0] rd;
            logic [REG_W-1:0] shamt;
            logic [FN_W-1:0]  funct;
        } rtype;
        struct packed {
            logic [OP_W-1:0]  op;
            logic [REG_W-1:0] rs;
            logic [REG_W-1:0] rt;
            logic [IMM_W-1:0] imm;
        } itype;
        struct packed {
            logic [OP_W-1:0]     op;
            logic [TARGET_W-1:0] target;
        } jtype;
    } instr_t;

endpackage

//--- mips_core_pkg.sv
package mips_core_pkg;

    localparam int DATA_W     = 32;
    localparam int IMEM_DEPTH = 64;
    localparam int IMEM_AW    = 6;
    localparam int DMEM_DEPTH = 16;
    localparam int DMEM_AW    = 4;

    // Main decoder to ALU control
    localparam int ALUOP_W = 2;
    localparam logic [ALUOP_W-1:0] ALUOP_ADD   = 2'd0;
    localparam logic [ALUOP_W-1:0] ALUOP_SUB   = 2'd1;
    localparam logic [ALUOP_W-1:0] ALUOP_FUNCT = 2'd2;

    // ALU functions
    localparam int ALU_FN_W = 4;
    localparam logic [ALU_FN_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_FN_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_FN_W-1:0] ALU_AND = 4'd2;
    localparam logic [ALU_FN_W-1:0] ALU_OR  = 4'd3;
    localparam logic [ALU_FN_W-1:0] ALU_SLT = 4'd4;
    localparam logic [ALU_FN_W-1:0] ALU_SLL = 4'd5;

    // Operand source chosen by the forwarding logic
    localparam int FWD_W = 2;
    localparam logic [FWD_W-1:0] FWD_NONE = 2'd0;
    localparam logic [FWD_W-1:0] FWD_MEM  = 2'd1;
    localparam logic [FWD_W-1:0] FWD_WB   = 2'd2;

endpackage

//--- pipe_if.sv
// Control levels of one decoded instruction
interface ctrl_if
    import mips_core_pkg::*;
();
    logic               reg_write;
    logic               mem_to_reg;
    logic               mem_write;
    logic               branch;
    logic               jump;
    logic               alu_src;
    logic               reg_dst;
    logic [ALUOP_W-1:0] alu_op;

    modport decoder (
        output reg_write, mem_to_reg, mem_write, branch, jump, alu_src, reg_dst, alu_op
    );
    modport stage (
        input reg_write, mem_to_reg, mem_write, branch, jump, alu_src, reg_dst, alu_op
    );
endinterface

// Results still in flight in MEM and WB
interface bypass_if
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
();
    logic              mem_we;
    logic [REG_W-1:0]  mem_dest;
    logic [DATA_W-1:0] mem_result;
    logic              wb_we;
    logic [REG_W-1:0]  wb_dest;
    logic [DATA_W-1:0] wb_data;

    modport source (output mem_we, mem_dest, mem_result, wb_we, wb_dest, wb_data);
    modport sink (input mem_we, mem_dest, mem_result, wb_we, wb_dest, wb_data);
endinterface

//--- fetch_unit.sv
module fetch_unit
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_jump,
    input  logic [DATA_W-1:0]  i_jump_target,
    input  logic               i_branch_taken,
    input  logic [DATA_W-1:0]  i_branch_target,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [DATA_W-1:0]  i_imem_data,
    output logic [DATA_W-1:0]  o_pc,
    output logic [DATA_W-1:0]  o_pc4,
    output instr_t             o_instr
);
    logic [DATA_W-1:0] imem [IMEM_DEPTH];
    logic [DATA_W-1:0] pc_next;

    assign o_pc4 = o_pc + DATA_W'(4);

    // The branch in MEM is older than the jump in EX
    assign pc_next = i_branch_taken ? i_branch_target :
                     i_jump         ? i_jump_target   : o_pc4;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_pc <= '0;
        end else begin
            o_pc <= pc_next;
        end
    end

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    // Word index from the PC above the byte offset
    assign o_instr = imem[o_pc[IMEM_AW+1:2]];

endmodule

//--- control_decoder.sv
module control_decoder
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic [OP_W-1:0] i_op,
    ctrl_if.decoder         ctrl
);

    always_comb begin
        // Unknown opcodes fall through as a nop
        ctrl.reg_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.reg_dst    = 1'b0;
        ctrl.alu_op     = ALUOP_ADD;
        case (i_op)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                ctrl.alu_op    = ALUOP_FUNCT;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALUOP_SUB;
            end
            OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- register_file.sv
module register_file
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic [REG_W-1:0]  i_rs,
    input  logic [REG_W-1:0]  i_rt,
    bypass_if.sink            wb,
    input  logic [REG_W-1:0]  i_dbg_addr,
    output logic [DATA_W-1:0] o_rs_data,
    output logic [DATA_W-1:0] o_rt_data,
    output logic [DATA_W-1:0] o_dbg_data
);
    logic [DATA_W-1:0] regs [2**REG_W];
    logic              wr_en;

    // $zero is never written
    assign wr_en = wb.wb_we && (wb.wb_dest != '0);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**REG_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.wb_dest] <= wb.wb_data;
        end
    end

    // Write in WB shows up in the same cycle's ID read
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end else if (wr_en && (wb.wb_dest == addr)) begin
            return wb.wb_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rs_data = read_port(i_rs);
        o_rt_data = read_port(i_rt);
    end

    assign o_dbg_data = regs[i_dbg_addr];

endmodule

//--- execute_unit.sv
module execute_unit
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  instr_t             i_instr,
    input  logic [DATA_W-1:0]  i_pc4,
    input  logic [DATA_W-1:0]  i_rs_data,
    input  logic [DATA_W-1:0]  i_rt_data,
    input  logic [DATA_W-1:0]  i_imm_ext,
    input  logic               i_alu_src,
    input  logic [ALUOP_W-1:0] i_alu_op,
    bypass_if.sink             byp,
    output logic [DATA_W-1:0]  o_result,
    output logic [DATA_W-1:0]  o_store_data,
    output logic               o_zero,
    output logic [DATA_W-1:0]  o_branch_target,
    output logic [DATA_W-1:0]  o_jump_target
);
    logic [ALU_FN_W-1:0] alu_fn;
    logic [FWD_W-1:0]    fwd_a;
    logic [FWD_W-1:0]    fwd_b;
    logic [DATA_W-1:0]   op_a;
    logic [DATA_W-1:0]   op_b;

    //////////////////////////////////////////////////
    // ALU control
    //////////////////////////////////////////////////
    always_comb begin
        alu_fn = ALU_ADD;
        if (i_alu_op == ALUOP_SUB) begin
            alu_fn = ALU_SUB;
        end else if (i_alu_op == ALUOP_FUNCT) begin
            case (i_instr.rtype.funct)
                FN_ADD:  alu_fn = ALU_ADD;
                FN_SUB:  alu_fn = ALU_SUB;
                FN_AND:  alu_fn = ALU_AND;
                FN_OR:   alu_fn = ALU_OR;
                FN_SLT:  alu_fn = ALU_SLT;
                FN_SLL:  alu_fn = ALU_SLL;
                default: alu_fn = ALU_ADD;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Forwarding
    //////////////////////////////////////////////////

    // The younger result in MEM wins over WB
    function automatic logic [FWD_W-1:0] fwd_sel(input logic [REG_W-1:0] src);
        if (byp.mem_we && (byp.mem_dest != '0) && (byp.mem_dest == src)) begin
            return FWD_MEM;
        end else if (byp.wb_we && (byp.wb_dest != '0) && (byp.wb_dest == src)) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic logic [DATA_W-1:0] fwd_mux(
        input logic [FWD_W-1:0]  sel,
        input logic [DATA_W-1:0] reg_data
    );
        case (sel)
            FWD_MEM: return byp.mem_result;
            FWD_WB:  return byp.wb_data;
            default: return reg_data;
        endcase
    endfunction

    always_comb begin
        fwd_a        = fwd_sel(i_instr.rtype.rs);
        fwd_b        = fwd_sel(i_instr.rtype.rt);
        op_a         = fwd_mux(fwd_a, i_rs_data);
        o_store_data = fwd_mux(fwd_b, i_rt_data);
        op_b         = i_alu_src ? i_imm_ext : o_store_data;
    end

    //////////////////////////////////////////////////
    // ALU and targets
    //////////////////////////////////////////////////
    always_comb begin
        case (alu_fn)
            ALU_SUB: o_result = op_a - op_b;
            ALU_AND: o_result = op_a & op_b;
            ALU_OR:  o_result = op_a | op_b;
            ALU_SLT: o_result = DATA_W'($signed(op_a) < $signed(op_b));
            // sll shifts rt by shamt
            ALU_SLL: o_result = op_b << i_instr.rtype.shamt;
            default: o_result = op_a + op_b;
        endcase
    end

    assign o_zero          = (o_result == '0);
    assign o_branch_target = i_pc4 + (i_imm_ext << 2);

    // Pseudo-direct target takes its upper bits from PC+4
    assign o_jump_target = {i_pc4[DATA_W-1:TARGET_W+2], i_instr.jtype.target, 2'b00};

endmodule

//--- data_mem.sv
module data_mem
    import mips_core_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic [DATA_W-1:0]  i_addr,
    input  logic               i_we,
    input  logic [DATA_W-1:0]  i_wdata,
    input  logic [DMEM_AW-1:0] i_dbg_addr,
    output logic [DATA_W-1:0]  o_rdata,
    output logic [DATA_W-1:0]  o_dbg_data
);
    logic [DATA_W-1:0]  mem [DMEM_DEPTH];
    logic [DMEM_AW-1:0] word_addr;

    // Byte address to word index
    assign word_addr = i_addr[DMEM_AW+1:2];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_we) begin
            mem[word_addr] <= i_wdata;
        end
    end

    assign o_rdata    = mem[word_addr];
    assign o_dbg_data = mem[i_dbg_addr];

endmodule

//--- mips_core.sv
module mips_core
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_arst_n,
    input  logic               i_imem_we,
    input  logic [IMEM_AW-1:0] i_imem_addr,
    input  logic [DATA_W-1:0]  i_imem_data,
    input  logic [REG_W-1:0]   i_dbg_reg_addr,
    input  logic [DMEM_AW-1:0] i_dbg_mem_addr,
    output logic [DATA_W-1:0]  o_pc,
    output logic [7:0]         o_ex_ctrl,
    output logic [DATA_W-1:0]  o_dbg_reg_data,
    output logic [DATA_W-1:0]  o_dbg_mem_data
);
    ctrl_if   ctrl ();
    bypass_if byp ();

    // IF and IF/ID
    logic [DATA_W-1:0]  if_pc4;
    instr_t             if_instr;
    logic [DATA_W-1:0]  if_id_pc4;
    instr_t             if_id_instr;

    // ID and ID/EX
    logic [DATA_W-1:0]  id_rs_data;
    logic [DATA_W-1:0]  id_rt_data;
    logic [DATA_W-1:0]  id_imm_ext;
    logic [REG_W-1:0]   id_dest;
    logic               id_ex_reg_write;
    logic               id_ex_mem_to_reg;
    logic               id_ex_mem_write;
    logic               id_ex_branch;
    logic               id_ex_jump;
    logic               id_ex_alu_src;
    logic [ALUOP_W-1:0] id_ex_alu_op;
    instr_t             id_ex_instr;
    logic [DATA_W-1:0]  id_ex_pc4;
    logic [DATA_W-1:0]  id_ex_rs_data;
    logic [DATA_W-1:0]  id_ex_rt_data;
    logic [DATA_W-1:0]  id_ex_imm;
    logic [REG_W-1:0]   id_ex_dest;

    // EX and EX/MEM
    logic [DATA_W-1:0]  ex_result;
    logic [DATA_W-1:0]  ex_store_data;
    logic               ex_zero;
    logic [DATA_W-1:0]  ex_branch_target;
    logic [DATA_W-1:0]  ex_jump_target;
    logic               ex_mem_reg_write;
    logic               ex_mem_mem_to_reg;
    logic               ex_mem_mem_write;
    logic               ex_mem_branch;
    logic               ex_mem_zero;
    logic [DATA_W-1:0]  ex_mem_result;
    logic [DATA_W-1:0]  ex_mem_store_data;
    logic [DATA_W-1:0]  ex_mem_branch_target;
    logic [REG_W-1:0]   ex_mem_dest;

    // MEM and MEM/WB
    logic [DATA_W-1:0]  mem_rdata;
    logic               mem_branch_taken;
    logic               mem_wb_reg_write;
    logic               mem_wb_mem_to_reg;
    logic [DATA_W-1:0]  mem_wb_result;
    logic [DATA_W-1:0]  mem_wb_rdata;
    logic [REG_W-1:0]   mem_wb_dest;

    //////////////////////////////////////////////////
    // Fetch
    //////////////////////////////////////////////////
    fetch_unit u_fetch_unit (
        .i_clk           (i_clk),
        .i_arst_n        (i_arst_n),
        .i_jump          (id_ex_jump),
        .i_jump_target   (ex_jump_target),
        .i_branch_taken  (mem_branch_taken),
        .i_branch_target (ex_mem_branch_target),
        .i_imem_we       (i_imem_we),
        .i_imem_addr     (i_imem_addr),
        .i_imem_data     (i_imem_data),
        .o_pc            (o_pc),
        .o_pc4           (if_pc4),
        .o_instr         (if_instr)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            if_id_pc4   <= '0;
            if_id_instr <= '0;
        end else begin
            if_id_pc4   <= if_pc4;
            if_id_instr <= if_instr;
        end
    end

    //////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////
    control_decoder u_control_decoder (
        .i_op (if_id_instr.rtype.op),
        .ctrl (ctrl)
    );

    register_file u_register_file (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs       (if_id_instr.rtype.rs),
        .i_rt       (if_id_instr.rtype.rt),
        .wb         (byp),
        .i_dbg_addr (i_dbg_reg_addr),
        .o_rs_data  (id_rs_data),
        .o_rt_data  (id_rt_data),
        .o_dbg_data (o_dbg_reg_data)
    );

    assign id_imm_ext = {{(DATA_W-IMM_W){if_id_instr.itype.imm[IMM_W-1]}},
                         if_id_instr.itype.imm};
    // Destination is fixed here so only 8 control bits travel on
    assign id_dest = ctrl.reg_dst ? if_id_instr.rtype.rd : if_id_instr.rtype.rt;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_ex_reg_write  <= 1'b0;
            id_ex_mem_to_reg <= 1'b0;
            id_ex_mem_write  <= 1'b0;
            id_ex_branch     <= 1'b0;
            id_ex_jump       <= 1'b0;
            id_ex_alu_src    <= 1'b0;
            id_ex_alu_op     <= '0;
            id_ex_instr      <= '0;
            id_ex_pc4        <= '0;
            id_ex_rs_data    <= '0;
            id_ex_rt_data    <= '0;
            id_ex_imm        <= '0;
            id_ex_dest       <= '0;
        end else begin
            id_ex_reg_write  <= ctrl.reg_write;
            id_ex_mem_to_reg <= ctrl.mem_to_reg;
            id_ex_mem_write  <= ctrl.mem_write;
            id_ex_branch     <= ctrl.branch;
            id_ex_jump       <= ctrl.jump;
            id_ex_alu_src    <= ctrl.alu_src;
            id_ex_alu_op     <= ctrl.alu_op;
            id_ex_instr      <= if_id_instr;
            id_ex_pc4        <= if_id_pc4;
            id_ex_rs_data    <= id_rs_data;
            id_ex_rt_data    <= id_rt_data;
            id_ex_imm        <= id_imm_ext;
            id_ex_dest       <= id_dest;
        end
    end

    assign o_ex_ctrl = {id_ex_alu_op, id_ex_alu_src, id_ex_jump, id_ex_branch,
                        id_ex_mem_write, id_ex_mem_to_reg, id_ex_reg_write};

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////
    execute_unit u_execute_unit (
        .i_instr         (id_ex_instr),
        .i_pc4           (id_ex_pc4),
        .i_rs_data       (id_ex_rs_data),
        .i_rt_data       (id_ex_rt_data),
        .i_imm_ext       (id_ex_imm),
        .i_alu_src       (id_ex_alu_src),
        .i_alu_op        (id_ex_alu_op),
        .byp             (byp),
        .o_result        (ex_result),
        .o_store_data    (ex_store_data),
        .o_zero          (ex_zero),
        .o_branch_target (ex_branch_target),
        .o_jump_target   (ex_jump_target)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ex_mem_reg_write     <= 1'b0;
            ex_mem_mem_to_reg    <= 1'b0;
            ex_mem_mem_write     <= 1'b0;
            ex_mem_branch        <= 1'b0;
            ex_mem_zero          <= 1'b0;
            ex_mem_result        <= '0;
            ex_mem_store_data    <= '0;
            ex_mem_branch_target <= '0;
            ex_mem_dest          <= '0;
        end else begin
            ex_mem_reg_write     <= id_ex_reg_write;
            ex_mem_mem_to_reg    <= id_ex_mem_to_reg;
            ex_mem_mem_write     <= id_ex_mem_write;
            ex_mem_branch        <= id_ex_branch;
            ex_mem_zero          <= ex_zero;
            ex_mem_result        <= ex_result;
            ex_mem_store_data    <= ex_store_data;
            ex_mem_branch_target <= ex_branch_target;
            ex_mem_dest          <= id_ex_dest;
        end
    end

    //////////////////////////////////////////////////
    // Memory and write-back
    //////////////////////////////////////////////////
    assign mem_branch_taken = ex_mem_branch && ex_mem_zero;

    data_mem u_data_mem (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_addr     (ex_mem_result),
        .i_we       (ex_mem_mem_write),
        .i_wdata    (ex_mem_store_data),
        .i_dbg_addr (i_dbg_mem_addr),
        .o_rdata    (mem_rdata),
        .o_dbg_data (o_dbg_mem_data)
    );

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            mem_wb_reg_write  <= 1'b0;
            mem_wb_mem_to_reg <= 1'b0;
            mem_wb_result     <= '0;
            mem_wb_rdata      <= '0;
            mem_wb_dest       <= '0;
        end else begin
            mem_wb_reg_write  <= ex_mem_reg_write;
            mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
            mem_wb_result     <= ex_mem_result;
            mem_wb_rdata      <= mem_rdata;
            mem_wb_dest       <= ex_mem_dest;
        end
    end

    // Bypass sources for EX and the register file write
    assign byp.mem_we     = ex_mem_reg_write;
    assign byp.mem_dest   = ex_mem_dest;
    assign byp.mem_result = ex_mem_result;
    assign byp.wb_we      = mem_wb_reg_write;
    assign byp.wb_dest    = mem_wb_dest;
    assign byp.wb_data    = mem_wb_mem_to_reg ? mem_wb_rdata : mem_wb_result;

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen (
    output logic o_clk
);
    localparam int HALF_PERIOD = 4;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

endmodule

//--- tb_mips.sv
module tb_mips
    import mips_isa_pkg::*;
    import mips_core_pkg::*;
();
    // Path markers of the two beq tests live in r14 and above
    localparam int FIRST_MARK_REG = 14;
    localparam int HALT_TIMEOUT   = 300;
    localparam int RESET_CYCLES   = 5;

    logic               clk;
    logic               arst_n;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [DATA_W-1:0]  imem_data;
    logic [REG_W-1:0]   dbg_reg_addr;
    logic [DMEM_AW-1:0] dbg_mem_addr;
    logic [DATA_W-1:0]  pc;
    logic [7:0]         ex_ctrl;
    logic [DATA_W-1:0]  dbg_reg_data;
    logic [DATA_W-1:0]  dbg_mem_data;

    logic [31:0] prog_addr [$];
    logic [31:0] prog_word [$];
    logic [31:0] reg_idx [$];
    logic [31:0] reg_exp [$];
    logic [31:0] mem_idx [$];
    logic [31:0] mem_exp [$];
    logic [31:0] halt_addr;
    logic        halt_found;

    int errors;
    int tests_run;
    int tests_failed;
    int test_start;

    tb_clock_gen u_clock_gen (
        .o_clk (clk)
    );

    mips_core dut (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_pc           (pc),
        .o_ex_ctrl      (ex_ctrl),
        .o_dbg_reg_data (dbg_reg_data),
        .o_dbg_mem_data (dbg_mem_data)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    task automatic read_stimulus();
        int          fd;
        int          n;
        logic [63:0] tag;
        logic [31:0] a;
        logic [31:0] v;
        logic [1023:0] skip_line;
        fd = $fopen("mips_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open stimulus file mips_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", tag);
            if (n != 1) begin
                break;
            end
            if (tag == "#") begin
                n = $fgets(skip_line, fd);
            end else if (tag == "I") begin
                n = $fscanf(fd, "%h %h", a, v);
                prog_addr.push_back(a);
                prog_word.push_back(v);
            end else if (tag == "H") begin
                n = $fscanf(fd, "%h", a);
                halt_addr  = a;
                halt_found = 1'b1;
            end else if (tag == "R") begin
                n = $fscanf(fd, "%h %h", a, v);
                reg_idx.push_back(a);
                reg_exp.push_back(v);
            end else if (tag == "M") begin
                n = $fscanf(fd, "%h %h", a, v);
                mem_idx.push_back(a);
                mem_exp.push_back(v);
            end else begin
                $display("unknown line tag %s in stimulus file", tag);
                errors++;
                n = $fgets(skip_line, fd);
            end
        end
        $fclose(fd);
    endtask

    // Each wait gives up after its own cycle budget
    task automatic wait_for_pc(input logic [31:0] target, input int max_cycles);
        int cycles;
        cycles = 0;
        while ((pc !== target) && (cycles < max_cycles)) begin
            @(negedge clk);
            cycles++;
        end
        if (pc !== target) begin
            $display("timeout waiting for o_pc to reach %h", target);
            errors++;
        end
    endtask

    // Debug reads settle for a full cycle before sampling
    task automatic check_regs(input bit markers);
        logic [31:0] idx;
        for (int i = 0; i < reg_idx.size(); i++) begin
            idx = reg_idx[i];
            if ((idx >= FIRST_MARK_REG) == markers) begin
                @(negedge clk);
                dbg_reg_addr = idx[REG_W-1:0];
                @(negedge clk);
                check($sformatf("r%0d", idx), dbg_reg_data, reg_exp[i]);
            end
        end
    endtask

    initial begin
        logic [31:0] word_addr;
        arst_n       = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_data    = '0;
        dbg_reg_addr = '0;
        dbg_mem_addr = '0;
        halt_addr    = '0;
        halt_found   = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_start   = 0;

        read_stimulus();
        if (!halt_found) begin
            $display("no halt address in stimulus file");
            errors++;
        end

        //////////////////////////////////////////////////
        // Program load and reset
        //////////////////////////////////////////////////
        for (int i = 0; i < prog_addr.size(); i++) begin
            @(negedge clk);
            word_addr = prog_addr[i];
            imem_we   = 1'b1;
            imem_addr = word_addr[IMEM_AW+1:2];
            imem_data = prog_word[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check("o_pc", pc, 32'h0);
            check("o_ex_ctrl", {24'h0, ex_ctrl}, 32'h0);
        end
        report_test("reset");

        // PC steps by 4 from the first edge after release
        arst_n = 1'b1;
        check("o_pc", pc, 32'h0);
        @(negedge clk);
        check("o_pc", pc, 32'h4);
        @(negedge clk);
        check("o_pc", pc, 32'h8);
        report_test("fetch");

        //////////////////////////////////////////////////
        // Halt loop
        //////////////////////////////////////////////////
        wait_for_pc(halt_addr, HALT_TIMEOUT);
        // j in EX lets two more words through, so the loop is three cycles long
        for (int i = 0; i < 9; i++) begin
            @(negedge clk);
            check("o_pc within halt loop",
                  {31'h0, (pc >= halt_addr) && (pc <= halt_addr + 32'h8)}, 32'h1);
        end
        check("o_pc", pc, halt_addr);
        report_test("halt");

        //////////////////////////////////////////////////
        // Results
        //////////////////////////////////////////////////
        check_regs(1'b0);
        report_test("registers");

        for (int i = 0; i < mem_idx.size(); i++) begin
            @(negedge clk);
            word_addr    = mem_idx[i];
            dbg_mem_addr = word_addr[DMEM_AW-1:0];
            @(negedge clk);
            check($sformatf("mem[%0d]", word_addr), dbg_mem_data, mem_exp[i]);
        end
        report_test("memory");

        check_regs(1'b1);
        report_test("branches");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- vlog.f
mips_isa_pkg.sv
mips_core_pkg.sv
pipe_if.sv
fetch_unit.sv
control_decoder.sv
register_file.sv
execute_unit.sv
data_mem.sv
mips_core.sv
tb_clock_gen.sv
tb_mips.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module tb_mips -Mdir obj_dir -f vlog.f
	@out="$$(./obj_dir/Vtb_mips)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

clean:
	rm -rf obj_dir

//--- mips_stimulus.txt
# I byte_address instruction_word | H halt_byte_address
# R register expected_value | M memory_word_index expected_value (all hex)
I 00 20010005
I 04 2002000e
I 08 00221820
I 0c 00612022
I 10 00832824
I 14 00a13025
I 18 0026382a
I 1c 00074100
I 20 2109fffd
I 24 00095022
I 28 0141582a
I 2c ac030004
I 30 ad0a0008
I 34 8c0c0004
I 38 00000000
I 3c 018c6820
I 40 ac0d000c
I 44 10220004
I 48 200e0001
I 4c 00000000
I 50 00000000
I 54 200f0002
I 58 10630004
I 5c 00000000
I 60 00000000
I 64 00000000
I 68 20100063
I 6c 20110007
I 70 0800001c
I 74 00000000
I 78 00000000
H 70
R 01 00000005
R 02 0000000e
R 03 00000013
R 04 0000000e
R 05 00000002
R 06 00000007
R 07 00000001
R 08 00000010
R 09 0000000d
R 0a fffffff3
R 0b 00000001
R 0c 00000013
R 0d 00000026
R 0e 00000001
R 0f 00000002
R 10 00000000
R 11 00000007
M 0 00000000
M 1 00000013
M 3 00000026
M 6 fffffff3
